// ==== Bender.yml ====
package:
  name: dac_interface

sources:
  - files:
      - rtl/dac_layout_pkg.sv
      - rtl/dac_wave_pkg.sv
      - rtl/dac_wave_if.sv
      - rtl/dac_cmd_capture.sv
      - rtl/dac_wave_gen.sv
      - rtl/dac_batch_out.sv
      - rtl/dac_interface.sv
  - target: test
    files:
      - verification/dac_batch_checker.sv
      - verification/dac_interface_tb.sv

// ==== all.f ====
rtl/dac_layout_pkg.sv
rtl/dac_wave_pkg.sv
rtl/dac_wave_if.sv
rtl/dac_cmd_capture.sv
rtl/dac_wave_gen.sv
rtl/dac_batch_out.sv
rtl/dac_interface.sv
verification/dac_batch_checker.sv
verification/dac_interface_tb.sv

// ==== rtl/dac_batch_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module dac_batch_out (
	input wire clk,
	input wire rst,
	input wire dac_layout_pkg::batch_t next_batch,
	input wire next_valid,
	output logic take,
	input wire dac_rdy,
	input wire halt,
	output dac_layout_pkg::batch_t dac_batch,
	output logic valid_dac_batch,
	output logic [1:0] valid_dac_edge
);

	logic valid_last; // valid_dac_batch one cycle back.

	// a halt also blocks the batch that would have gone out with it.
	assign take = next_valid && dac_rdy && !halt;

	always_ff @(posedge clk) begin
		if (rst) begin
			dac_batch <= '0;
			valid_dac_batch <= 1'b0;
		end else begin
			valid_dac_batch <= take;
			if (halt) begin
				dac_batch <= '0;
			end else if (take) begin
				dac_batch <= next_batch;
			end
		end
	end

	// edge flags come one cycle after the edge of valid_dac_batch.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_last <= 1'b0;
			valid_dac_edge <= 2'b00;
		end else begin
			valid_last <= valid_dac_batch;
			valid_dac_edge[0] <= valid_dac_batch && !valid_last;
			valid_dac_edge[1] <= !valid_dac_batch && valid_last;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dac_cmd_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module dac_cmd_capture (
	input wire clk,
	input wire rst,
	input wire dac_layout_pkg::fresh_t fresh_bits,
	input wire dac_layout_pkg::slot_word_t [dac_layout_pkg::mem_size-1:0] read_resps,
	input wire halt,
	output logic state_rdy,
	dac_wave_if.capture wave
);
	import dac_layout_pkg::*;
	import dac_wave_pkg::*;

	fresh_t consume;
	logic start_random;
	logic start_triangle;

	// the table is not read in the cycle a new mode is loaded.
	assign state_rdy = ~wave.load;

	assign consume = state_rdy ? fresh_bits : '0;

	assign start_random = consume[seed_valid_id] && (read_resps[seed_valid_id] != '0);
	assign start_triangle = consume[trig_wave_id] && (read_resps[trig_wave_id] != '0);

	// generation and output see the halt in the same cycle.
	assign wave.halt = halt;

	always_ff @(posedge clk) begin
		for (int i = 0; i < batch_samples; i++) begin
			if (consume[seed_base_id + i]) begin
				wave.seeds[i] <= read_resps[seed_base_id + i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wave.load <= 1'b0;
			wave.mode <= mode_idle;
		end else if (halt) begin
			wave.load <= 1'b0; // a command taken with a halt is dropped.
			wave.mode <= mode_idle;
		end else if (start_random) begin
			wave.load <= 1'b1; // random wins over a triangle trigger in the same cycle.
			wave.mode <= mode_random;
		end else if (start_triangle) begin
			wave.load <= 1'b1;
			wave.mode <= mode_triangle;
		end else begin
			wave.load <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dac_interface.sv ====
`timescale 1ns/1ns
`default_nettype none

module dac_interface (
	input wire clk,
	input wire rst,
	input wire dac_layout_pkg::fresh_t fresh_bits,
	input wire dac_layout_pkg::slot_word_t [dac_layout_pkg::mem_size-1:0] read_resps,
	input wire halt,
	input wire dac_rdy,
	output logic state_rdy,
	output dac_layout_pkg::batch_t dac_batch,
	output logic valid_dac_batch,
	output logic [1:0] valid_dac_edge
);
	import dac_layout_pkg::*;

	batch_t next_batch;
	logic next_valid;
	logic take;

	dac_wave_if wave_bus ();

	dac_cmd_capture capture0 (
		.clk(clk),
		.rst(rst),
		.fresh_bits(fresh_bits),
		.read_resps(read_resps),
		.halt(halt),
		.state_rdy(state_rdy),
		.wave(wave_bus.capture)
	);

	dac_wave_gen gen0 (
		.clk(clk),
		.rst(rst),
		.wave(wave_bus.gen),
		.next_batch(next_batch),
		.next_valid(next_valid),
		.take(take)
	);

	dac_batch_out out0 (
		.clk(clk),
		.rst(rst),
		.next_batch(next_batch),
		.next_valid(next_valid),
		.take(take),
		.dac_rdy(dac_rdy),
		.halt(halt),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch),
		.valid_dac_edge(valid_dac_edge)
	);

endmodule

`default_nettype wire

// ==== rtl/dac_layout_pkg.sv ====
`default_nettype none

package dac_layout_pkg;

	// sample and batch geometry.
	localparam int sample_width = 16;
	localparam int batch_samples = 4;
	localparam int batch_width = sample_width * batch_samples;

	// command table geometry.
	localparam int mem_size = 6;
	localparam int seed_base_id = 0; // four seed slots start here, one per lane.
	localparam int seed_valid_id = 4;
	localparam int trig_wave_id = 5;

	typedef logic [sample_width-1:0] sample_t;

	// sample 0 sits in the low bits.
	typedef logic [batch_width-1:0] batch_t;

	typedef logic [15:0] slot_word_t;

	typedef logic [mem_size-1:0] fresh_t; // one fresh bit per slot.

endpackage

`default_nettype wire

// ==== rtl/dac_wave_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module dac_wave_gen (
	input wire clk,
	input wire rst,
	dac_wave_if.gen wave,
	output dac_layout_pkg::batch_t next_batch,
	output logic next_valid,
	input wire take
);
	import dac_layout_pkg::*;
	import dac_wave_pkg::*;

	typedef enum logic {
		dir_up,
		dir_down
	} tri_dir_t;

	sample_t [batch_samples-1:0] lfsr; // lane states of the last batch.
	sample_t [batch_samples-1:0] lfsr_next;
	sample_t tri_val; // first sample of the next triangle batch.
	sample_t tri_val_next;
	tri_dir_t tri_dir;
	tri_dir_t tri_dir_next;
	batch_t rand_batch;
	batch_t tri_batch;
	logic step;

	// a batch is computed on load, and again once the waiting one has gone.
	assign step = wave.load || (!next_valid && (wave.mode != mode_idle));

	always_comb begin : lfsr_step
		sample_t s;
		for (int i = 0; i < batch_samples; i++) begin
			s = wave.load ? wave.seeds[i] : lfsr[i];
			if (s == '0) begin
				s = sample_t'(1); // an all zero state would lock the lane.
			end
			lfsr_next[i] = s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
			rand_batch[i*sample_width +: sample_width] = lfsr_next[i];
		end
	end

	always_comb begin : tri_walk
		sample_t v;
		tri_dir_t d;
		v = wave.load ? '0 : tri_val;
		d = wave.load ? dir_up : tri_dir;
		for (int i = 0; i < batch_samples; i++) begin
			tri_batch[i*sample_width +: sample_width] = v;
			if (d == dir_up) begin
				if (v + tri_step > tri_peak) begin
					d = dir_down;
					v = v - tri_step;
				end else begin
					v = v + tri_step;
				end
			end else begin
				if (v < tri_step) begin
					d = dir_up; // the next value would drop below zero.
					v = v + tri_step;
				end else begin
					v = v - tri_step;
				end
			end
		end
		tri_val_next = v;
		tri_dir_next = d;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			next_valid <= 1'b0;
			tri_dir <= dir_up;
		end else if (wave.halt) begin
			next_valid <= 1'b0;
		end else if (step) begin
			next_valid <= 1'b1;
			if (wave.mode == mode_triangle) begin
				tri_dir <= tri_dir_next;
			end
		end else if (take) begin
			next_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (step) begin
			if (wave.mode == mode_triangle) begin
				tri_val <= tri_val_next;
				next_batch <= tri_batch;
			end else begin
				lfsr <= lfsr_next;
				next_batch <= rand_batch;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dac_wave_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface dac_wave_if;
	import dac_layout_pkg::*;
	import dac_wave_pkg::*;

	wave_mode_t mode;
	slot_word_t [batch_samples-1:0] seeds; // seed word for each lane.
	logic load; // one cycle pulse when a new mode begins.
	logic halt;

	modport capture (
		output mode,
		output seeds,
		output load,
		output halt
	);

	modport gen (
		input mode,
		input seeds,
		input load,
		input halt
	);

endinterface

`default_nettype wire

// ==== rtl/dac_wave_pkg.sv ====
`default_nettype none

package dac_wave_pkg;

	typedef enum logic [1:0] {
		mode_idle,
		mode_random,
		mode_triangle
	} wave_mode_t;

	// each lane shifts right through this galois feedback mask once per batch.
	localparam logic [15:0] lfsr_taps = 16'hB400;

	// the triangle runs between 0 and tri_peak in equal steps.
	localparam logic [15:0] tri_step = 16'd256;
	localparam logic [15:0] tri_peak = 16'd32512; // 127 steps above zero.

endpackage

`default_nettype wire

// ==== verification/dac_batch_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module dac_batch_checker (
	input wire clk,
	input wire rst,
	input wire dac_layout_pkg::fresh_t fresh_bits,
	input wire dac_layout_pkg::slot_word_t [dac_layout_pkg::mem_size-1:0] read_resps,
	input wire halt,
	input wire dac_rdy,
	input wire state_rdy,
	input wire dac_layout_pkg::batch_t dac_batch,
	input wire valid_dac_batch,
	input wire [1:0] valid_dac_edge
);
	import dac_layout_pkg::*;
	import dac_wave_pkg::*;

	int error_count = 0;
	batch_t expected_q[$]; // first batches of the coming random runs.
	wave_mode_t mode;
	logic load_seen; // a start was taken in the cycle before.
	logic valid_d1;
	logic valid_d2;
	logic rdy_d1;
	int run_batches; // batches seen since the last random start.
	batch_t last_batch;
	sample_t tri_next; // the triangle sample due next.
	logic tri_up;

	function automatic sample_t galois_step(input sample_t s);
		sample_t r;
		r = s >> 1;
		if (s[0]) begin
			r = r ^ lfsr_taps;
		end
		return r;
	endfunction

	task automatic add_expected(input batch_t b);
		expected_q.push_back(b);
	endtask

	task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
		error_count++;
		$display("ERROR %s: expected 0x%0h, actual 0x%0h at %0t", name, exp, act, $time);
	endtask

	task automatic failure(input string what);
		error_count++;
		$display("%s at %0t", what, $time);
	endtask

	task automatic compare_random();
		batch_t exp;
		if (run_batches < 3) begin
			if (expected_q.size() == 0) begin
				failure("a random batch came out with no expected batch left from the vectors");
				exp = dac_batch;
			end else begin
				exp = expected_q.pop_front();
			end
		end else begin
			for (int i = 0; i < batch_samples; i++) begin
				exp[i*sample_width +: sample_width] =
					galois_step(last_batch[i*sample_width +: sample_width]);
			end
		end
		if (dac_batch !== exp) begin
			mismatch("dac_batch", exp, dac_batch);
		end
		last_batch = dac_batch; // each lane steps from what was shown.
	endtask

	task automatic follow_triangle();
		sample_t s;
		for (int i = 0; i < batch_samples; i++) begin
			s = dac_batch[i*sample_width +: sample_width];
			if (s !== tri_next) begin
				mismatch($sformatf("dac_batch sample %0d", i), tri_next, s);
			end
			if (s > tri_peak) begin
				failure("a triangle sample rose above the peak");
			end
			if (tri_up && (tri_next + tri_step > tri_peak)) begin
				tri_up = 1'b0;
			end else if (!tri_up && (tri_next < tri_step)) begin
				tri_up = 1'b1; // the next step down would go below zero.
			end
			tri_next = tri_up ? tri_next + tri_step : tri_next - tri_step;
		end
	endtask

	task automatic leftover_expected();
		if (expected_q.size() != 0) begin
			failure($sformatf("%0d expected random batches were never shown", expected_q.size()));
		end
	endtask

	always @(posedge clk) begin : watch
		fresh_t consume;
		logic start_random;
		logic start_triangle;
		if (rst) begin
			mode = mode_idle;
			load_seen = 1'b0;
			valid_d1 = 1'b0;
			valid_d2 = 1'b0;
			rdy_d1 = 1'b1;
		end else begin
			consume = state_rdy ? fresh_bits : '0;
			start_random = consume[seed_valid_id] && (read_resps[seed_valid_id] != '0);
			start_triangle = consume[trig_wave_id] && (read_resps[trig_wave_id] != '0);
			if (state_rdy !== !load_seen) begin
				mismatch("state_rdy", !load_seen, state_rdy);
			end
			if (valid_dac_edge !== {valid_d2 && !valid_d1, valid_d1 && !valid_d2}) begin
				mismatch("valid_dac_edge", {valid_d2 && !valid_d1, valid_d1 && !valid_d2},
					valid_dac_edge);
			end
			if (valid_dac_batch === 1'b1 && !rdy_d1) begin
				failure("a batch was shown although dac_rdy was low in the cycle before");
			end
			if (mode == mode_idle) begin
				if (valid_dac_batch !== 1'b0) begin
					mismatch("valid_dac_batch", 0, valid_dac_batch);
				end
				if (dac_batch !== '0) begin
					mismatch("dac_batch", 0, dac_batch);
				end
			end else if (valid_dac_batch === 1'b1) begin
				if (mode == mode_random) begin
					compare_random();
					run_batches++;
				end else begin
					follow_triangle();
				end
			end
			load_seen = 1'b0;
			if (halt) begin
				mode = mode_idle; // outputs are zero from the next cycle on.
			end else if (start_random) begin
				mode = mode_random;
				run_batches = 0;
				load_seen = 1'b1;
			end else if (start_triangle) begin
				mode = mode_triangle;
				tri_next = '0;
				tri_up = 1'b1;
				load_seen = 1'b1;
			end
			valid_d2 = valid_d1;
			valid_d1 = valid_dac_batch;
			rdy_d1 = dac_rdy;
		end
	end

endmodule

`default_nettype wire

// ==== verification/dac_interface_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dac_interface_tb;
	import dac_layout_pkg::*;
	import dac_wave_pkg::*;

	localparam int consume_limit = 20; // cycles for a fresh slot to be taken.
	localparam int batch_limit = 200; // cycles from a start to its first batch.

	logic clk = 1'b0;
	logic rst;
	fresh_t fresh_bits;
	slot_word_t [mem_size-1:0] read_resps;
	logic halt;
	logic dac_rdy = 1'b0;
	logic state_rdy;
	batch_t dac_batch;
	logic valid_dac_batch;
	logic [1:0] valid_dac_edge;

	logic [31:0] rdy_lfsr = 32'hff762404;
	int stimulus_errors = 0;

	dac_interface dut0 (
		.clk(clk),
		.rst(rst),
		.fresh_bits(fresh_bits),
		.read_resps(read_resps),
		.halt(halt),
		.dac_rdy(dac_rdy),
		.state_rdy(state_rdy),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch),
		.valid_dac_edge(valid_dac_edge)
	);

	dac_batch_checker checker0 (
		.clk(clk),
		.rst(rst),
		.fresh_bits(fresh_bits),
		.read_resps(read_resps),
		.halt(halt),
		.dac_rdy(dac_rdy),
		.state_rdy(state_rdy),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch),
		.valid_dac_edge(valid_dac_edge)
	);

	function automatic logic [31:0] rdy_lfsr_step(input logic [31:0] s);
		logic [31:0] r;
		r = s >> 1;
		if (s[0]) begin
			r = r ^ 32'h80200003;
		end
		return r;
	endfunction

	initial begin
		forever begin
			#50 clk = ~clk;
		end
	end

	always @(negedge clk) begin
		rdy_lfsr = rdy_lfsr_step(rdy_lfsr);
		dac_rdy = rdy_lfsr[0]; // one fresh bit per cycle.
	end

	task automatic skip_line(input int fd);
		int c;
		c = $fgetc(fd);
		while (c != "\n" && c != -1) begin
			c = $fgetc(fd);
		end
	endtask

	task automatic write_slot(input int slot, input slot_word_t word);
		int n;
		logic taken;
		@(negedge clk);
		read_resps[slot] = word;
		fresh_bits[slot] = 1'b1;
		taken = 1'b0;
		n = 0;
		while (!taken && n < consume_limit) begin
			@(posedge clk);
			taken = state_rdy; // the slot is consumed on this edge.
			n++;
		end
		if (!taken) begin
			$display("timeout: slot %0d was not consumed in %0d cycles", slot, consume_limit);
			stimulus_errors++;
		end
		@(negedge clk);
		fresh_bits[slot] = 1'b0;
	endtask

	task automatic wait_first_batch();
		int n;
		logic seen;
		seen = 1'b0;
		n = 0;
		while (!seen && n < batch_limit) begin
			@(posedge clk);
			seen = valid_dac_batch;
			n++;
		end
		if (!seen) begin
			$display("timeout: no batch came out in %0d cycles after a start", batch_limit);
			stimulus_errors++;
		end
	endtask

	task automatic pulse_halt();
		@(negedge clk);
		halt = 1'b1;
		@(negedge clk);
		halt = 1'b0;
	endtask

	initial begin : stimulus
		int fd;
		int code;
		int slot;
		int run;
		logic [7:0] kind;
		slot_word_t word;
		batch_t batch;
		rst = 1'b1;
		halt = 1'b0;
		fresh_bits = '0;
		read_resps = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		fd = $fopen("verification/dac_vectors.txt", "r");
		if (fd == 0) begin
			$display("the vector file could not be opened");
			stimulus_errors++;
		end else begin
			code = $fscanf(fd, " %c", kind);
			while (code == 1) begin
				case (kind)
					"#": begin
						skip_line(fd);
					end
					"w": begin
						code = $fscanf(fd, "%d %h %d", slot, word, run);
						write_slot(slot, word);
						if ((slot == seed_valid_id || slot == trig_wave_id) && word != '0) begin
							wait_first_batch();
						end
						repeat (run) @(negedge clk);
					end
					"h": begin
						code = $fscanf(fd, "%d", run);
						pulse_halt();
						repeat (run) @(negedge clk);
					end
					"e": begin
						code = $fscanf(fd, "%h", batch);
						checker0.add_expected(batch);
					end
					default: begin
						$display("the vector file holds a line of unknown kind %c", kind);
						stimulus_errors++;
						skip_line(fd);
					end
				endcase
				code = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
		end
		repeat (4) @(negedge clk);
		checker0.leftover_expected();
		$display("errors: %0d from the checker, %0d from the stimulus",
			checker0.error_count, stimulus_errors);
		if (checker0.error_count == 0 && stimulus_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/dac_vectors.txt ====
# w slot word run writes one command slot with a hex word and then runs for run cycles
# h run pulses halt and then runs for run cycles
# e batch gives an expected random batch in hex with sample 0 in the low bits
w 0 0000 2
w 1 ace1 2
w 2 1234 2
w 3 ffff 2
# a start word of zero starts nothing
w 4 0000 20
w 5 0000 10
e cbff091ae270b400
e d1ff048d71385a00
e dcffb646389c2d00
w 4 0001 150
h 12
# the triangle runs long enough to pass the peak and come back to zero
w 5 0001 320
h 12
# the seeds are held, so a new start repeats the same first batches
e cbff091ae270b400
e d1ff048d71385a00
e dcffb646389c2d00
w 4 00ff 90
h 12
w 4 0000 15
w 5 0a0a 60
h 20
